//--- verilog/spi_regs_pkg.sv
package spi_regs_pkg;

    // ==============================
    // Frame and word sizes
    // ==============================

    localparam int ADDR_W  = 7;                      // Register address bits
    localparam int DATA_W  = 64;                     // Register word bits
    localparam int FRAME_W = 1 + ADDR_W + DATA_W;    // rw + addr + data = 72

    typedef logic [ADDR_W-1:0] addr_t;               // Register address
    typedef logic [DATA_W-1:0] data_t;               // Register value

    // ==============================
    // Register map
    // ==============================

    localparam addr_t REG_ID         = 7'h00;        // Read-only chip ID
    localparam addr_t REG_SCRATCH    = 7'h01;        // Free read/write word
    localparam addr_t REG_TMR_CTRL   = 7'h02;        // Bit 0 enables the timer
    localparam addr_t REG_TMR_PERIOD = 7'h03;        // Wrap length, write restarts count
    localparam addr_t REG_TMR_COUNT  = 7'h04;        // Live count, read-only
    localparam addr_t REG_IRQ_STAT   = 7'h05;        // Bit 0 sticky, write 1 to clear

    // Fixed ID word seen at REG_ID
    localparam data_t CHIP_ID = 64'h0047_5055_0001_0000;

endpackage

//--- verilog/interval_timer.sv
module interval_timer #(
    parameter int TMR_W = spi_regs_pkg::DATA_W   // Counter width
) (
    input  logic             sys_clk,
    input  logic             sys_rst_n,
    input  logic             tmr_en,        // Count while high, hold while low
    input  logic [TMR_W-1:0] tmr_period,    // Cycles per wrap, 0 acts as 1
    input  logic             period_load,   // New period written, restart at 0
    output logic [TMR_W-1:0] tmr_count,     // Live count
    output logic             tmr_tick       // High in the wrap cycle
);

    // ==============================
    // Wrap detect
    // ==============================

    logic [TMR_W-1:0] last_cnt;   // Final count before wrap
    logic             at_last;

    // Period 0 and 1 both wrap every cycle
    assign last_cnt = (tmr_period == '0) ? '0 : tmr_period - TMR_W'(1);
    assign at_last  = (tmr_count == last_cnt);

    assign tmr_tick = tmr_en && at_last;   // Disabled timer never ticks

    // ==============================
    // Counter
    // ==============================

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tmr_count <= '0;
        end else if (period_load) begin
            tmr_count <= '0;                 // Restart even while disabled
        end else if (tmr_en) begin
            if (at_last) begin
                tmr_count <= '0;             // Wrap with the tick
            end else begin
                tmr_count <= tmr_count + TMR_W'(1);
            end
        end
    end

endmodule

//--- verilog/ctrl_regs.sv
module ctrl_regs #(
    parameter int TMR_W = spi_regs_pkg::DATA_W   // Timer width, at most DATA_W
) (
    input  logic                sys_clk,
    input  logic                sys_rst_n,

    // Frame from the SPI slave
    input  logic                valid,
    input  logic                rw,
    input  spi_regs_pkg::addr_t addr,
    input  spi_regs_pkg::data_t wdata,
    output spi_regs_pkg::data_t rdata,        // Read snapshot back to MISO

    // Timer
    input  logic [TMR_W-1:0]    tmr_count,
    input  logic                tmr_tick,
    output logic                tmr_en,
    output logic [TMR_W-1:0]    tmr_period,
    output logic                period_load,  // Restart pulse on period write

    output logic                irq           // Sticky timer interrupt
);

    logic                wr_en;      // Write frame this cycle
    logic                rd_en;      // Read frame this cycle
    logic                irq_clr;    // Write 1 to status bit 0
    spi_regs_pkg::data_t scratch;
    spi_regs_pkg::data_t rd_mux;     // Addressed register, before snapshot

    assign wr_en = valid && !rw;
    assign rd_en = valid && rw;

    assign period_load = wr_en && (addr == spi_regs_pkg::REG_TMR_PERIOD);
    assign irq_clr     = wr_en && (addr == spi_regs_pkg::REG_IRQ_STAT) && wdata[0];

    // ==============================
    // Write decode
    // ==============================

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scratch    <= '0;
            tmr_en     <= 1'b0;
            tmr_period <= '0;
        end else if (wr_en) begin
            case (addr)
                spi_regs_pkg::REG_SCRATCH:    scratch    <= wdata;
                spi_regs_pkg::REG_TMR_CTRL:   tmr_en     <= wdata[0];
                spi_regs_pkg::REG_TMR_PERIOD: tmr_period <= wdata[TMR_W-1:0];
                default: ;                   // ID, count, status and holes ignore data
            endcase
        end
    end

    // Set has priority so a tick is never lost
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            irq <= 1'b0;
        end else if (tmr_tick) begin
            irq <= 1'b1;
        end else if (irq_clr) begin
            irq <= 1'b0;
        end
    end

    // ==============================
    // Read path
    // ==============================

    // Narrow timer fields are zero-extended by the casts
    always_comb begin
        case (addr)
            spi_regs_pkg::REG_ID:         rd_mux = spi_regs_pkg::CHIP_ID;
            spi_regs_pkg::REG_SCRATCH:    rd_mux = scratch;
            spi_regs_pkg::REG_TMR_CTRL:   rd_mux = spi_regs_pkg::data_t'(tmr_en);
            spi_regs_pkg::REG_TMR_PERIOD: rd_mux = spi_regs_pkg::data_t'(tmr_period);
            spi_regs_pkg::REG_TMR_COUNT:  rd_mux = spi_regs_pkg::data_t'(tmr_count);
            spi_regs_pkg::REG_IRQ_STAT:   rd_mux = spi_regs_pkg::data_t'(irq);
            default:                      rd_mux = '0;   // Unmapped
        endcase
    end

    // Snapshot is shifted out during the following frame
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= rd_mux;
        end
    end

endmodule

//--- verilog/spi_slave.sv
module spi_slave (
    // SPI pins
    input  logic                spi_sck,    // Host clock that idles low
    input  logic                spi_mosi,   // Host to slave data
    input  logic                spi_cs_n,   // Active-low frame select
    output logic                spi_miso,   // Slave to host data

    // System side
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  spi_regs_pkg::data_t rdata,      // Snapshot from the register block
    output logic                valid,      // One-cycle frame strobe
    output logic                rw,         // 1 = read
    output spi_regs_pkg::addr_t addr,
    output spi_regs_pkg::data_t wdata
);

    localparam int FRAME_W = spi_regs_pkg::FRAME_W;
    localparam int ADDR_W  = spi_regs_pkg::ADDR_W;
    localparam int DATA_W  = spi_regs_pkg::DATA_W;
    localparam int CNT_W   = $clog2(FRAME_W + 1);  // Must count up to 72
    localparam int IDX_W   = $clog2(DATA_W);       // Bit index into rdata

    // ==============================
    // SCK domain receive
    // ==============================

    logic [FRAME_W-1:0] shift_reg;   // Incoming frame, MSB first
    logic [CNT_W-1:0]   bit_cnt;     // Rising edges seen this frame
    logic               done_spi;    // Full frame received

    // Counter and flag restart whenever the host drops the frame
    always_ff @(posedge spi_sck or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            bit_cnt  <= '0;
            done_spi <= 1'b0;
        end else if (bit_cnt < CNT_W'(FRAME_W)) begin
            bit_cnt <= bit_cnt + CNT_W'(1);
            if (bit_cnt == CNT_W'(FRAME_W - 1)) begin
                done_spi <= 1'b1;                    // Last bit goes in on this edge
            end
        end
    end

    // Shifting stops once all 72 bits are in
    always_ff @(posedge spi_sck) begin
        if (!spi_cs_n && bit_cnt < CNT_W'(FRAME_W)) begin
            shift_reg <= {shift_reg[FRAME_W-2:0], spi_mosi};
        end
    end

    // ==============================
    // SCK domain transmit
    // ==============================

    logic [IDX_W-1:0] miso_idx;   // rdata bit for the next host sample
    logic             miso_q;     // Falling-edge data
    logic             miso_run;   // At least one falling edge this frame

    assign miso_idx = IDX_W'(DATA_W - 1) - bit_cnt[IDX_W-1:0];

    // Each falling edge presents the bit the host samples on the next rising edge
    always_ff @(negedge spi_sck or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            miso_q   <= 1'b0;
            miso_run <= 1'b0;
        end else begin
            miso_run <= 1'b1;
            if (bit_cnt < CNT_W'(DATA_W)) begin
                miso_q <= rdata[miso_idx];
            end else begin
                miso_q <= 1'b0;                      // Trailing 8 bits read as zero
            end
        end
    end

    // Before the first falling edge the MSB must already sit on the pin
    assign spi_miso = miso_run ? miso_q : (!spi_cs_n && rdata[DATA_W-1]);

    // ==============================
    // Crossing into sys_clk
    // ==============================

    logic done_meta;     // First stage that may go metastable
    logic done_sync;     // Safe copy
    logic done_sync_d;   // Delayed copy for edge detect
    logic done_rise;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            done_meta   <= 1'b0;
            done_sync   <= 1'b0;
            done_sync_d <= 1'b0;
        end else begin
            done_meta   <= done_spi;
            done_sync   <= done_meta;
            done_sync_d <= done_sync;
        end
    end

    assign done_rise = done_sync && !done_sync_d;   // Once per frame

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= done_rise;
        end
    end

    // Fields hold until the next frame lands
    // The shift register has been quiet since the last SCK edge
    always_ff @(posedge sys_clk) begin
        if (done_rise) begin
            rw    <= shift_reg[FRAME_W-1];
            addr  <= shift_reg[FRAME_W-2 -: ADDR_W];
            wdata <= shift_reg[DATA_W-1:0];
        end
    end

endmodule

//--- verilog/spi_ctrl_top.sv
module spi_ctrl_top #(
    parameter int TMR_W = spi_regs_pkg::DATA_W   // Timer counter width
) (
    input  logic sys_clk,
    input  logic sys_rst_n,

    // Host SPI pins, mode 0
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic spi_cs_n,
    output logic spi_miso,

    output logic irq        // Timer interrupt to the host
);

    // ==============================
    // Internal nets
    // ==============================

    logic                valid;        // Frame strobe
    logic                rw;
    spi_regs_pkg::addr_t addr;
    spi_regs_pkg::data_t wdata;
    spi_regs_pkg::data_t rdata;        // Read snapshot
    logic                tmr_en;
    logic [TMR_W-1:0]    tmr_period;
    logic                period_load;
    logic [TMR_W-1:0]    tmr_count;
    logic                tmr_tick;

    // Host frames in, read data out
    spi_slave u_spi_slave (
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .spi_miso  (spi_miso),
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rdata     (rdata),
        .valid     (valid),
        .rw        (rw),
        .addr      (addr),
        .wdata     (wdata)
    );

    ctrl_regs #(
        .TMR_W (TMR_W)
    ) u_ctrl_regs (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .valid       (valid),
        .rw          (rw),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .tmr_count   (tmr_count),
        .tmr_tick    (tmr_tick),
        .tmr_en      (tmr_en),
        .tmr_period  (tmr_period),
        .period_load (period_load),
        .irq         (irq)
    );

    // Interval timer steered by the registers
    interval_timer #(
        .TMR_W (TMR_W)
    ) u_interval_timer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .tmr_en      (tmr_en),
        .tmr_period  (tmr_period),
        .period_load (period_load),
        .tmr_count   (tmr_count),
        .tmr_tick    (tmr_tick)
    );

endmodule

//--- verification/spi_ctrl_assert.sv
module spi_ctrl_assert (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic valid,       // Frame strobe from the SPI slave
    input logic tmr_en,
    input logic irq
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;   // Count of failed assertions

    // Frame strobe never stretches past one cycle
    valid_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        valid |=> !valid)
        else begin
            fail_cnt++;
            $error("valid stayed high for more than one sys_clk");
        end

    // A new interrupt only follows a cycle with the timer enabled
    irq_needs_enable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(irq) |-> $past(tmr_en))
        else begin
            fail_cnt++;
            $error("irq rose although the timer was disabled");
        end

    // First clock out of reset sees irq clear
    irq_low_after_reset: assert property (@(posedge sys_clk)
        $rose(sys_rst_n) |-> !irq)
        else begin
            fail_cnt++;
            $error("irq was high right after reset");
        end

endmodule

bind spi_ctrl_top spi_ctrl_assert u_assert (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .valid     (valid),
    .tmr_en    (tmr_en),
    .irq       (irq)
);

//--- verification/spi_ctrl_tb.sv
module spi_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCK_HALF     = 4;     // sys_clk cycles per SCK half period
    localparam int FRAME_GAP    = 8;     // Idle cycles between frames
    localparam int STROBE_LIMIT = 20;    // Max cycles from last SCK edge to valid
    localparam int IRQ_LIMIT    = 500;   // Max cycles to wait for the timer interrupt

    logic sys_clk;
    logic sys_rst_n;
    logic spi_sck;
    logic spi_mosi;
    logic spi_cs_n;
    logic spi_miso;
    logic irq;

    spi_ctrl_top DUT (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .spi_miso  (spi_miso),
        .irq       (irq)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;   // 20 ns period
    end

    // ==============================
    // Error handling and compares
    // ==============================

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_data(input spi_regs_pkg::data_t got, input spi_regs_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s read %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // ==============================
    // SPI host side
    // ==============================

    task automatic half_sck();
        repeat (SCK_HALF) @(negedge sys_clk);
    endtask

    // One mode 0 frame; returns the 64 bits seen on MISO
    task automatic spi_frame(input logic rd, input spi_regs_pkg::addr_t a,
                             input spi_regs_pkg::data_t d,
                             output spi_regs_pkg::data_t miso_word);
        logic [spi_regs_pkg::FRAME_W-1:0] frame;
        int k;
        int n;
        frame     = {rd, a, d};
        miso_word = '0;
        spi_cs_n  = 1'b0;
        for (k = 0; k < spi_regs_pkg::FRAME_W; k++) begin
            spi_mosi = frame[spi_regs_pkg::FRAME_W-1];        // MSB first
            frame    = {frame[spi_regs_pkg::FRAME_W-2:0], 1'b0};
            half_sck();
            if (k < spi_regs_pkg::DATA_W) begin
                miso_word = {miso_word[spi_regs_pkg::DATA_W-2:0], spi_miso};  // Sample before rise
            end
            spi_sck = 1'b1;
            if (k < spi_regs_pkg::FRAME_W - 1) begin
                half_sck();
                spi_sck = 1'b0;
            end
        end
        // Chip select stays low until the frame strobe is seen
        n = 0;
        while (DUT.valid !== 1'b1) begin
            @(negedge sys_clk);
            n++;
            if (n > STROBE_LIMIT) begin
                report_timeout("no frame strobe after the 72nd SCK edge");
            end
        end
        spi_sck = 1'b0;
        half_sck();
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        repeat (FRAME_GAP) @(negedge sys_clk);   // Lets the read snapshot settle
    endtask

    task automatic write_reg(input spi_regs_pkg::addr_t a, input spi_regs_pkg::data_t d);
        spi_regs_pkg::data_t unused;
        spi_frame(1'b0, a, d, unused);
    endtask

    task automatic read_reg(input spi_regs_pkg::addr_t a, output spi_regs_pkg::data_t value);
        spi_regs_pkg::data_t unused;
        spi_frame(1'b1, a, '0, unused);
        spi_frame(1'b1, spi_regs_pkg::REG_ID, '0, value);   // Dummy frame carries the snapshot
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic id_readback();
        spi_regs_pkg::data_t value;
        check_bit(irq, 1'b0, "irq after reset");
        read_reg(spi_regs_pkg::REG_ID, value);
        check_data(value, 64'h0047_5055_0001_0000, "chip ID");
    endtask

    task automatic scratch_readback();
        spi_regs_pkg::data_t wr_val;
        spi_regs_pkg::data_t value;
        int i;
        for (i = 0; i < 4; i++) begin
            wr_val = {$urandom, $urandom};
            write_reg(spi_regs_pkg::REG_SCRATCH, wr_val);
            read_reg(spi_regs_pkg::REG_SCRATCH, value);
            check_data(value, wr_val, "scratch");
        end
        write_reg(7'h40, {$urandom, $urandom});   // Hole in the map
        read_reg(spi_regs_pkg::REG_SCRATCH, value);
        check_data(value, wr_val, "scratch after unmapped write");
        read_reg(7'h40, value);
        check_data(value, '0, "unmapped address");
    endtask

    task automatic timer_irq();
        spi_regs_pkg::data_t value;
        int n;
        write_reg(spi_regs_pkg::REG_TMR_PERIOD, 64'd50);
        write_reg(spi_regs_pkg::REG_TMR_CTRL, 64'd1);
        n = 0;
        while (irq !== 1'b1) begin
            @(negedge sys_clk);
            n++;
            if (n > IRQ_LIMIT) begin
                report_timeout("irq never rose with the timer running");
            end
        end
        read_reg(spi_regs_pkg::REG_IRQ_STAT, value);
        check_data(value, 64'd1, "interrupt status while set");
    endtask

    task automatic irq_clear();
        spi_regs_pkg::data_t value;
        write_reg(spi_regs_pkg::REG_TMR_CTRL, 64'd0);   // No more ticks
        write_reg(spi_regs_pkg::REG_IRQ_STAT, 64'd1);
        check_bit(irq, 1'b0, "irq after clear");
        read_reg(spi_regs_pkg::REG_IRQ_STAT, value);
        check_data(value, 64'd0, "interrupt status after clear");
    endtask

    task automatic count_hold();
        spi_regs_pkg::data_t count_a;
        spi_regs_pkg::data_t count_b;
        read_reg(spi_regs_pkg::REG_TMR_COUNT, count_a);
        read_reg(spi_regs_pkg::REG_TMR_COUNT, count_b);
        check_data(count_b, count_a, "held count");
        check_bit(count_a < 64'd50, 1'b1, "count below period");
        write_reg(spi_regs_pkg::REG_TMR_PERIOD, 64'd100);   // Restarts the count
        read_reg(spi_regs_pkg::REG_TMR_PERIOD, count_a);
        check_data(count_a, 64'd100, "new period");
        read_reg(spi_regs_pkg::REG_TMR_COUNT, count_b);
        check_data(count_b, 64'd0, "count after period write");
    endtask

    initial begin
        sys_rst_n = 1'b0;
        spi_sck   = 1'b0;   // Mode 0 idles low
        spi_mosi  = 1'b0;
        spi_cs_n  = 1'b1;
        void'($urandom(32'hb287));
        repeat (5) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);

        id_readback();
        scratch_readback();
        timer_irq();
        irq_clear();
        count_hold();

        if (DUT.u_assert.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", DUT.u_assert.fail_cnt);
            stop_run();
        end
    end

endmodule

//--- flist.f
verilog/spi_regs_pkg.sv
verilog/interval_timer.sv
verilog/ctrl_regs.sv
verilog/spi_slave.sv
verilog/spi_ctrl_top.sv
verification/spi_ctrl_assert.sv
verification/spi_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI control port testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f flist.f --top-module spi_ctrl_tb \
    -o spi_ctrl_sim > build.log 2>&1 \
    && ./obj_dir/spi_ctrl_sim > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
